// ==== design/noc_calc_pkg.sv ====
// mesh calculator shared definitions
// mesh size, flit layout, op codes and the host register map

package noc_calc_pkg;

    // --------------------
    // mesh geometry
    // --------------------

    // tiles per side
    localparam int mesh_dim = 3;

    typedef logic [1:0] coord_t;

    // --------------------
    // operations
    // --------------------

    typedef logic [3:0] op_t;

    localparam op_t op_add = 4'd0;
    localparam op_t op_sub = 4'd1;
    localparam op_t op_mul = 4'd2;
    localparam op_t op_div = 4'd3;
    localparam op_t op_and = 4'd4;
    localparam op_t op_or  = 4'd5;
    localparam op_t op_xor = 4'd6;
    localparam op_t op_shl = 4'd7;
    localparam op_t op_shr = 4'd8;

    // anything above this is refused by the host block
    localparam op_t op_max = op_shr;

    typedef logic [63:0] word_t;

    // --------------------
    // flit
    // --------------------

    // one flit carries a whole request or response
    // a response reuses the a field for its result
    typedef struct packed {
        logic   valid;
        logic   resp;
        coord_t dst_x;
        coord_t dst_y;
        op_t    op;
        word_t  a;
        word_t  b;
    } noc_flit_t;

    // --------------------
    // apb register map
    // --------------------

    localparam logic [7:0] reg_a_lo   = 8'h00;
    localparam logic [7:0] reg_a_hi   = 8'h04;
    localparam logic [7:0] reg_b_lo   = 8'h08;
    localparam logic [7:0] reg_b_hi   = 8'h0C;
    localparam logic [7:0] reg_ctrl   = 8'h10;
    localparam logic [7:0] reg_status = 8'h14;
    localparam logic [7:0] reg_res_lo = 8'h18;
    localparam logic [7:0] reg_res_hi = 8'h1C;

    // bit positions inside STATUS
    localparam int status_busy = 0;
    localparam int status_done = 1;
    localparam int status_err  = 2;

endpackage

// ==== design/noc_alu.sv ====
// noc_alu
// combinational 64-bit operation unit, one per mesh tile

`timescale 1ns/1ps

module noc_alu (
    input  noc_calc_pkg::op_t   op,
    input  noc_calc_pkg::word_t a,
    input  noc_calc_pkg::word_t b,
    output noc_calc_pkg::word_t result
);

    // shifts only look at the low six bits of b
    logic [5:0] shamt;

    assign shamt = b[5:0];

    always_comb begin
        case (op)
            noc_calc_pkg::op_add: result = a + b;
            noc_calc_pkg::op_sub: result = a - b;
            // low half of the product
            noc_calc_pkg::op_mul: result = a * b;
            noc_calc_pkg::op_div: begin
                if (b == '0) begin
                    result = '0;
                end else begin
                    result = a / b;
                end
            end
            noc_calc_pkg::op_and: result = a & b;
            noc_calc_pkg::op_or:  result = a | b;
            noc_calc_pkg::op_xor: result = a ^ b;
            noc_calc_pkg::op_shl: result = a << shamt;
            noc_calc_pkg::op_shr: result = a >> shamt;
            default:              result = '0;
        endcase
    end

endmodule

// ==== design/noc_tile.sv ====
// noc_tile
// one mesh node with a flit register, Y-then-X request routing, response
// routing back to (0,0) and in-place request to response conversion

`timescale 1ns/1ps

module noc_tile #(
    parameter noc_calc_pkg::coord_t tile_x = '0,
    parameter noc_calc_pkg::coord_t tile_y = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  noc_calc_pkg::noc_flit_t in_n,
    input  noc_calc_pkg::noc_flit_t in_e,
    input  noc_calc_pkg::noc_flit_t in_s,
    input  noc_calc_pkg::noc_flit_t in_w,
    input  noc_calc_pkg::noc_flit_t in_local,
    output noc_calc_pkg::noc_flit_t out_n,
    output noc_calc_pkg::noc_flit_t out_e,
    output noc_calc_pkg::noc_flit_t out_s,
    output noc_calc_pkg::noc_flit_t out_w,
    output noc_calc_pkg::noc_flit_t out_local
);

    noc_calc_pkg::noc_flit_t flit_q;
    noc_calc_pkg::noc_flit_t in_sel;
    noc_calc_pkg::noc_flit_t resp_flit;
    noc_calc_pkg::word_t     alu_result;

    logic go_n, go_e, go_s, go_w, go_local;
    logic at_dst;

    noc_alu alu_i (
        .op     (flit_q.op),
        .a      (flit_q.a),
        .b      (flit_q.b),
        .result (alu_result)
    );

    // --------------------
    // input select
    // --------------------

    // only one flit exists, so the order here never matters
    always_comb begin
        in_sel = '0;
        if (in_local.valid) begin
            in_sel = in_local;
        end else if (in_n.valid) begin
            in_sel = in_n;
        end else if (in_e.valid) begin
            in_sel = in_e;
        end else if (in_s.valid) begin
            in_sel = in_s;
        end else if (in_w.valid) begin
            in_sel = in_w;
        end
    end

    // --------------------
    // route decision
    // --------------------

    always_comb begin
        go_n     = 1'b0;
        go_e     = 1'b0;
        go_s     = 1'b0;
        go_w     = 1'b0;
        go_local = 1'b0;
        at_dst   = 1'b0;
        if (flit_q.valid && !flit_q.resp) begin
            // requests settle the row first
            if (tile_y < flit_q.dst_y) begin
                go_s = 1'b1;
            end else if (tile_y > flit_q.dst_y) begin
                go_n = 1'b1;
            end else if (tile_x < flit_q.dst_x) begin
                go_e = 1'b1;
            end else if (tile_x > flit_q.dst_x) begin
                go_w = 1'b1;
            end else begin
                at_dst = 1'b1;
            end
        end else if (flit_q.valid) begin
            // responses climb to row 0, then head west
            if (tile_y != '0) begin
                go_n = 1'b1;
            end else if (tile_x != '0) begin
                go_w = 1'b1;
            end else begin
                go_local = 1'b1;
            end
        end
    end

    assign out_n     = go_n     ? flit_q : '0;
    assign out_e     = go_e     ? flit_q : '0;
    assign out_s     = go_s     ? flit_q : '0;
    assign out_w     = go_w     ? flit_q : '0;
    assign out_local = go_local ? flit_q : '0;

    // response formed in place and addressed back to the host tile
    always_comb begin
        resp_flit       = flit_q;
        resp_flit.resp  = 1'b1;
        resp_flit.dst_x = '0;
        resp_flit.dst_y = '0;
        resp_flit.a     = alu_result;
        resp_flit.b     = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flit_q <= '0;
        end else if (at_dst) begin
            flit_q <= resp_flit;
        end else begin
            flit_q <= in_sel;
        end
    end

    // --------------------
    // checks
    // --------------------

    // neighbours and the host together never send two flits at once
    a_one_input: assert property (@(posedge clk) disable iff (reset)
        $onehot0({in_n.valid, in_e.valid, in_s.valid, in_w.valid, in_local.valid}));

    // with one flit in the mesh a tile never sends and receives in the same cycle
    a_one_flit: assert property (@(posedge clk) disable iff (reset)
        (out_n.valid || out_e.valid || out_s.valid || out_w.valid || out_local.valid)
        |-> !(in_n.valid || in_e.valid || in_s.valid || in_w.valid || in_local.valid));

    // a response sent south or east by a neighbour would arrive on in_n or in_w
    a_resp_dir: assert property (@(posedge clk) disable iff (reset)
        !((in_n.valid && in_n.resp) || (in_w.valid && in_w.resp)));

endmodule

// ==== design/noc_mesh.sv ====
// noc_mesh
// 3x3 array of tiles; host traffic enters and leaves at tile (0,0)

`timescale 1ns/1ps

module noc_mesh (
    input  logic                    clk,
    input  logic                    reset,
    input  noc_calc_pkg::noc_flit_t inject,
    output noc_calc_pkg::noc_flit_t eject
);

    localparam int dim = noc_calc_pkg::mesh_dim;

    // tile outputs, indexed [row][column]
    noc_calc_pkg::noc_flit_t to_n     [dim][dim];
    noc_calc_pkg::noc_flit_t to_e     [dim][dim];
    noc_calc_pkg::noc_flit_t to_s     [dim][dim];
    noc_calc_pkg::noc_flit_t to_w     [dim][dim];
    noc_calc_pkg::noc_flit_t to_local [dim][dim];

    for (genvar gy = 0; gy < dim; gy++) begin : g_row
        for (genvar gx = 0; gx < dim; gx++) begin : g_col
            noc_calc_pkg::noc_flit_t in_n, in_e, in_s, in_w, in_local;

            // each side samples the neighbour's port that faces it
            if (gy > 0) begin : g_n
                assign in_n = to_s[gy-1][gx];
            end else begin : g_n_edge
                assign in_n = '0;
            end

            if (gy < dim - 1) begin : g_s
                assign in_s = to_n[gy+1][gx];
            end else begin : g_s_edge
                assign in_s = '0;
            end

            if (gx > 0) begin : g_w
                assign in_w = to_e[gy][gx-1];
            end else begin : g_w_edge
                assign in_w = '0;
            end

            if (gx < dim - 1) begin : g_e
                assign in_e = to_w[gy][gx+1];
            end else begin : g_e_edge
                assign in_e = '0;
            end

            // host port exists only at the corner
            if (gx == 0 && gy == 0) begin : g_host
                assign in_local = inject;
            end else begin : g_no_host
                assign in_local = '0;
            end

            noc_tile #(
                .tile_x (noc_calc_pkg::coord_t'(gx)),
                .tile_y (noc_calc_pkg::coord_t'(gy))
            ) tile_i (
                .clk       (clk),
                .reset     (reset),
                .in_n      (in_n),
                .in_e      (in_e),
                .in_s      (in_s),
                .in_w      (in_w),
                .in_local  (in_local),
                .out_n     (to_n[gy][gx]),
                .out_e     (to_e[gy][gx]),
                .out_s     (to_s[gy][gx]),
                .out_w     (to_w[gy][gx]),
                .out_local (to_local[gy][gx])
            );
        end
    end

    assign eject = to_local[0][0];

endmodule

// ==== design/noc_host_apb.sv ====
// noc_host_apb
// APB register file: holds operands, builds the request flit for tile
// (0,0) and collects the returning result

`timescale 1ns/1ps

module noc_host_apb (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [7:0]              paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output noc_calc_pkg::noc_flit_t inject,
    input  noc_calc_pkg::noc_flit_t eject
);

    noc_calc_pkg::word_t a_q, b_q, res_q;
    noc_calc_pkg::op_t   op_q;
    logic                busy, done, err;
    logic                inject_valid;

    logic access, mapped, read_only, ctrl_hit, wr_en, start;

    // --------------------
    // apb decode
    // --------------------

    assign access   = psel && penable;
    assign ctrl_hit = (paddr == noc_calc_pkg::reg_ctrl);

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        prdata    = '0;
        case (paddr)
            noc_calc_pkg::reg_a_lo: prdata = a_q[31:0];
            noc_calc_pkg::reg_a_hi: prdata = a_q[63:32];
            noc_calc_pkg::reg_b_lo: prdata = b_q[31:0];
            noc_calc_pkg::reg_b_hi: prdata = b_q[63:32];
            noc_calc_pkg::reg_ctrl: prdata = {28'd0, op_q};
            noc_calc_pkg::reg_status: begin
                read_only = 1'b1;
                prdata[noc_calc_pkg::status_busy] = busy;
                prdata[noc_calc_pkg::status_done] = done;
                prdata[noc_calc_pkg::status_err]  = err;
            end
            noc_calc_pkg::reg_res_lo: begin
                read_only = 1'b1;
                prdata    = res_q[31:0];
            end
            noc_calc_pkg::reg_res_hi: begin
                read_only = 1'b1;
                prdata    = res_q[63:32];
            end
            default: mapped = 1'b0;
        endcase
    end

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && read_only) || (pwrite && ctrl_hit && busy));

    assign wr_en = access && pwrite && !pslverr;
    assign start = wr_en && ctrl_hit && (noc_calc_pkg::op_t'(pwdata[3:0]) <= noc_calc_pkg::op_max);

    // operand registers
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (paddr)
                noc_calc_pkg::reg_a_lo: a_q[31:0]  <= pwdata;
                noc_calc_pkg::reg_a_hi: a_q[63:32] <= pwdata;
                noc_calc_pkg::reg_b_lo: b_q[31:0]  <= pwdata;
                noc_calc_pkg::reg_b_hi: b_q[63:32] <= pwdata;
                noc_calc_pkg::reg_ctrl: op_q       <= pwdata[3:0];
                default: ;
            endcase
        end
    end

    // --------------------
    // request control
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            done         <= 1'b0;
            err          <= 1'b0;
            inject_valid <= 1'b0;
            res_q        <= '0;
        end else begin
            inject_valid <= start;
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
                err  <= 1'b0;
            end else if (wr_en && ctrl_hit) begin
                // op code out of range, nothing goes out
                err  <= 1'b1;
                done <= 1'b0;
            end
            if (eject.valid) begin
                res_q <= eject.a;
                done  <= 1'b1;
                busy  <= 1'b0;
            end
        end
    end

    // destination tile comes straight from the op code
    always_comb begin
        inject       = '0;
        inject.valid = inject_valid;
        inject.dst_x = noc_calc_pkg::coord_t'(op_q % noc_calc_pkg::mesh_dim);
        inject.dst_y = noc_calc_pkg::coord_t'(op_q / noc_calc_pkg::mesh_dim);
        inject.op    = op_q;
        inject.a     = a_q;
        inject.b     = b_q;
    end

    // a new flit only follows a fresh start, never an earlier flit
    a_inject_fresh: assert property (@(posedge clk) disable iff (reset)
        inject.valid |-> $rose(busy));

    a_eject_busy: assert property (@(posedge clk) disable iff (reset)
        eject.valid |-> busy);

endmodule

// ==== design/noc_calc.sv ====
// noc_calc
// top level: APB host block feeding the 3x3 ALU mesh

`timescale 1ns/1ps

module noc_calc (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    noc_calc_pkg::noc_flit_t inject;
    noc_calc_pkg::noc_flit_t eject;

    noc_host_apb host_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .inject  (inject),
        .eject   (eject)
    );

    noc_mesh mesh_i (
        .clk    (clk),
        .reset  (reset),
        .inject (inject),
        .eject  (eject)
    );

endmodule

// ==== dv/noc_calc_tb.sv ====
// noc_calc testbench
// drives the APB host port through every op, the edge cases and the error paths;
// concurrent assertions compare bus responses and done latency with expected values

`timescale 1ns/1ps

module noc_calc_tb;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // expectations seen by the assertions
    logic        rd_check;
    logic [31:0] rd_expect;
    logic        err_expect;
    int          lat_expect;
    int          lat_cnt;

    logic [31:0] lfsr_state;
    int          errors;
    int          err_mark;
    int          tests;
    int          failed_tests;

    noc_calc noc_calc_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #2 clk = ~clk;

    // cycles since the last accepted CTRL write, edge 0 being its access edge
    always @(posedge clk) begin
        if (reset) begin
            lat_cnt <= 0;
        end else if (psel && penable && pwrite && paddr == noc_calc_pkg::reg_ctrl && !pslverr) begin
            lat_cnt <= 0;
        end else begin
            lat_cnt <= lat_cnt + 1;
        end
    end

    // --------------------
    // checks
    // --------------------

    a_ready: assert property (@(posedge clk) disable iff (reset)
        (psel && penable) |-> pready)
        else begin
            errors++;
            $display("[FAIL] pready expected 1 got %h", $sampled(pready));
        end

    a_slverr: assert property (@(posedge clk) disable iff (reset)
        (psel && penable) |-> (pslverr == err_expect))
        else begin
            errors++;
            $display("[FAIL] pslverr at %h expected %h got %h", $sampled(paddr),
                     $sampled(err_expect), $sampled(pslverr));
        end

    a_rdata: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !pwrite && rd_check) |-> (prdata == rd_expect))
        else begin
            errors++;
            $display("[FAIL] prdata at %h expected %h got %h", $sampled(paddr),
                     $sampled(rd_expect), $sampled(prdata));
        end

    // done rises 2h+3 edges after the CTRL access
    a_latency: assert property (@(posedge clk) disable iff (reset)
        $rose(noc_calc_i.host_i.done) |-> (lat_cnt == lat_expect))
        else begin
            errors++;
            $display("[FAIL] done latency expected %h got %h", $sampled(lat_expect),
                     $sampled(lat_cnt));
        end

    // --------------------
    // stimulus helpers
    // --------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic rand_word(output noc_calc_pkg::word_t w);
        for (int i = 0; i < 64; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i] = lfsr_state[0];
        end
    endtask

    // operation table of the calculator
    function automatic noc_calc_pkg::word_t expected_result(input int op,
            input noc_calc_pkg::word_t a, input noc_calc_pkg::word_t b);
        int unsigned sh;
        sh = b % 64;
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a * b;
            3: return (b == 0) ? 64'd0 : a / b;
            4: return a & b;
            5: return a | b;
            6: return a ^ b;
            7: return a << sh;
            8: return a >> sh;
            default: return 64'd0;
        endcase
    endfunction

    task automatic finish_access(output logic [31:0] data);
        int   waits;
        logic ready;
        waits = 0;
        ready = 1'b0;
        data  = '0;
        while (!ready && waits < 8) begin
            @(negedge clk);
            ready = pready;
            data  = prdata;
            waits++;
            @(posedge clk);
        end
        if (!ready) begin
            errors++;
            $display("no pready within 8 cycles at address %h", paddr);
        end
        psel     <= 1'b0;
        penable  <= 1'b0;
        rd_check <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic bad);
        logic [31:0] unused;
        @(posedge clk);
        psel       <= 1'b1;
        pwrite     <= 1'b1;
        paddr      <= addr;
        pwdata     <= data;
        err_expect <= bad;
        @(posedge clk);
        penable <= 1'b1;
        finish_access(unused);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic check, input logic [31:0] want,
                            input logic bad, output logic [31:0] data);
        @(posedge clk);
        psel       <= 1'b1;
        pwrite     <= 1'b0;
        paddr      <= addr;
        rd_check   <= check;
        rd_expect  <= want;
        err_expect <= bad;
        @(posedge clk);
        penable <= 1'b1;
        finish_access(data);
    endtask

    task automatic start_op(input int op, input noc_calc_pkg::word_t a,
                            input noc_calc_pkg::word_t b);
        write_reg(noc_calc_pkg::reg_a_lo, a[31:0], 1'b0);
        write_reg(noc_calc_pkg::reg_a_hi, a[63:32], 1'b0);
        write_reg(noc_calc_pkg::reg_b_lo, b[31:0], 1'b0);
        write_reg(noc_calc_pkg::reg_b_hi, b[63:32], 1'b0);
        lat_expect = 2 * (op % noc_calc_pkg::mesh_dim + op / noc_calc_pkg::mesh_dim) + 3;
        write_reg(noc_calc_pkg::reg_ctrl, 32'(op), 1'b0);
    endtask

    // poll STATUS until done, then read the result back
    task automatic collect_result(input noc_calc_pkg::word_t want);
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[noc_calc_pkg::status_done] && polls < 40) begin
            read_reg(noc_calc_pkg::reg_status, 1'b0, '0, 1'b0, status);
            polls++;
        end
        if (!status[noc_calc_pkg::status_done]) begin
            errors++;
            $display("done was not set within 40 status reads");
        end
        read_reg(noc_calc_pkg::reg_status, 1'b1, 32'd1 << noc_calc_pkg::status_done, 1'b0, status);
        read_reg(noc_calc_pkg::reg_res_lo, 1'b1, want[31:0], 1'b0, status);
        read_reg(noc_calc_pkg::reg_res_hi, 1'b1, want[63:32], 1'b0, status);
    endtask

    task automatic run_op(input int op, input noc_calc_pkg::word_t a,
                          input noc_calc_pkg::word_t b);
        start_op(op, a, b);
        collect_result(expected_result(op, a, b));
    endtask

    task automatic end_test(input string name);
        // let the assertion action blocks of the last access run first
        repeat (2) @(posedge clk);
        tests++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // --------------------
    // test sequence
    // --------------------

    initial begin
        noc_calc_pkg::word_t a;
        noc_calc_pkg::word_t b;
        logic [31:0]         data;

        clk          = 1'b0;
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        rd_check     = 1'b0;
        rd_expect    = '0;
        err_expect   = 1'b0;
        lat_expect   = 0;
        lfsr_state   = 32'hdb20;
        errors       = 0;
        err_mark     = 0;
        tests        = 0;
        failed_tests = 0;

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        read_reg(noc_calc_pkg::reg_status, 1'b1, '0, 1'b0, data);
        read_reg(noc_calc_pkg::reg_res_lo, 1'b1, '0, 1'b0, data);
        read_reg(noc_calc_pkg::reg_res_hi, 1'b1, '0, 1'b0, data);
        end_test("reset");

        // each op also checks its own latency
        for (int op = 0; op <= 8; op++) begin
            rand_word(a);
            rand_word(b);
            run_op(op, a, b);
        end
        end_test("operations");

        rand_word(a);
        run_op(noc_calc_pkg::op_div, a, 64'd0);
        run_op(noc_calc_pkg::op_shl, a, 64'h41);
        run_op(noc_calc_pkg::op_shr, a, 64'h41);
        end_test("edge cases");

        // a second CTRL write while the longest route is in flight
        rand_word(a);
        rand_word(b);
        start_op(noc_calc_pkg::op_shr, a, b);
        write_reg(noc_calc_pkg::reg_ctrl, 32'(noc_calc_pkg::op_add), 1'b1);
        collect_result(expected_result(8, a, b));
        end_test("busy write");

        write_reg(noc_calc_pkg::reg_ctrl, 32'd9, 1'b0);
        read_reg(noc_calc_pkg::reg_status, 1'b1, 32'd1 << noc_calc_pkg::status_err, 1'b0, data);
        write_reg(noc_calc_pkg::reg_ctrl, 32'd15, 1'b0);
        read_reg(noc_calc_pkg::reg_status, 1'b1, 32'd1 << noc_calc_pkg::status_err, 1'b0, data);
        end_test("bad op");

        write_reg(8'h20, 32'h1234_5678, 1'b1);
        read_reg(8'h40, 1'b0, '0, 1'b1, data);
        write_reg(noc_calc_pkg::reg_status, 32'h7, 1'b1);
        write_reg(noc_calc_pkg::reg_res_lo, 32'h1, 1'b1);
        write_reg(noc_calc_pkg::reg_res_hi, 32'h1, 1'b1);
        end_test("bus errors");

        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== noc_calc.f ====
design/noc_calc_pkg.sv
design/noc_alu.sv
design/noc_tile.sv
design/noc_mesh.sv
design/noc_host_apb.sv
design/noc_calc.sv
dv/noc_calc_tb.sv

// ==== Bender.yml ====
package:
  name: noc_calc

sources:
  - files:
      - design/noc_calc_pkg.sv
      - design/noc_alu.sv
      - design/noc_tile.sv
      - design/noc_mesh.sv
      - design/noc_host_apb.sv
      - design/noc_calc.sv
  - target: test
    files:
      - dv/noc_calc_tb.sv
